/* source/mul_pkg.sv */
// Multiplier widths, adder group size and the bundle types passed between pipeline stages
`default_nettype none

package mul_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    // Each operand
    localparam int OPERAND_WIDTH = 32;

    // Full product, also used for every padded partial product and partial sum
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // Bits covered by one carry-lookahead group
    localparam int CLA_GROUP_WIDTH = 4;

    // Partial sums left after the two adder levels in front of the stage register
    localparam int FRONT_SUMS = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // Captured operands, one item per valid cycle
    typedef struct packed {
        logic     valid;
        operand_t a;
        operand_t b;
    } operand_bundle_t;

    // Partial sums held between the front and back reduction stages
    typedef struct packed {
        logic                          valid;
        product_t [FRONT_SUMS-1:0]     sums;
    } stage_bundle_t;

endpackage

`default_nettype wire

/* source/cla_adder.sv */
// Carry-lookahead adder made of lookahead groups with a rippled group carry
`timescale 1ns/1ns
`default_nettype none

module cla_adder #(
    parameter int width = mul_pkg::PRODUCT_WIDTH
) (
    input  wire logic [width-1:0] x,
    input  wire logic [width-1:0] y,
    output logic      [width-1:0] sum
);

    localparam int group_width = mul_pkg::CLA_GROUP_WIDTH;
    localparam int groups = width / group_width;

    logic [width-1:0]  prop;
    logic [width-1:0]  gen;
    logic [groups-1:0] group_carry;

    // Carry into bit position bit_index of one group, in sum-of-products form
    function automatic logic lookahead_carry(
        input logic [group_width-1:0] prop_grp,
        input logic [group_width-1:0] gen_grp,
        input logic                   carry_in,
        input int                     bit_index
    );
        logic term;
        logic carry;
        carry = carry_in;
        for (int k = 0; k < bit_index; k++) begin
            carry = carry & prop_grp[k];
        end
        for (int k = 0; k < bit_index; k++) begin
            term = gen_grp[k];
            for (int m = k + 1; m < bit_index; m++) begin
                term = term & prop_grp[m];
            end
            carry = carry | term;
        end
        return carry;
    endfunction

    assign prop = x ^ y;
    assign gen  = x & y;

    // No carry into the lowest group
    assign group_carry[0] = 1'b0;

    for (genvar gi = 0; gi < groups; gi++) begin : g_group
        localparam int base = gi * group_width;

        logic [group_width-1:0] carry;

        always_comb begin
            for (int j = 0; j < group_width; j++) begin
                carry[j] = lookahead_carry(prop[base +: group_width], gen[base +: group_width],
                                           group_carry[gi], j);
            end
        end

        assign sum[base +: group_width] = prop[base +: group_width] ^ carry;

        // Carry out of the top group would be past the product width
        if (gi < groups - 1) begin : g_carry_out
            assign group_carry[gi + 1] = lookahead_carry(prop[base +: group_width],
                                                         gen[base +: group_width],
                                                         group_carry[gi], group_width);
        end
    end

endmodule

`default_nettype wire

/* source/operand_capture.sv */
// Input stage that registers both operands and a valid flag on start
`timescale 1ns/1ns
`default_nettype none

module operand_capture (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire mul_pkg::operand_t a,
    input  wire mul_pkg::operand_t b,
    output mul_pkg::operand_bundle_t operands
);

    ////////////////////////////////////////////////////////////////////////////
    // Operand registers

    // Valid follows start every cycle, operands only load with it
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            operands <= '0;
        end else begin
            operands.valid <= start;
            if (start) begin
                operands.a <= a;
                operands.b <= b;
            end
        end
    end

endmodule

`default_nettype wire

/* source/reduction_front.sv */
// Partial product generation, first two adder levels and the stage register
`timescale 1ns/1ns
`default_nettype none

module reduction_front (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire mul_pkg::operand_bundle_t operands,
    output mul_pkg::stage_bundle_t        stage
);

    // One partial product per bit of b
    localparam int partials = mul_pkg::OPERAND_WIDTH;

    // Sums after the first level
    localparam int level0_sums = partials / 2;

    // Sums after the second level, held in the stage register
    localparam int level1_sums = mul_pkg::FRONT_SUMS;

    wire mul_pkg::product_t [partials-1:0]    partial;
    wire mul_pkg::product_t [level0_sums-1:0] level0;
    wire mul_pkg::product_t [level1_sums-1:0] level1;

    ////////////////////////////////////////////////////////////////////////////
    // Partial products

    // a gated by bit i of b, zero-extended and shifted into place
    for (genvar i = 0; i < partials; i++) begin : g_partial
        assign partial[i] = mul_pkg::product_t'(operands.a & {mul_pkg::OPERAND_WIDTH{operands.b[i]}})
                            << i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Adder levels 0 and 1

    // Pairwise sums of neighboring partial products
    for (genvar i = 0; i < level0_sums; i++) begin : g_level0
        cla_adder #(
            .width (mul_pkg::PRODUCT_WIDTH)
        ) u_add (
            .x   (partial[2*i]),
            .y   (partial[2*i + 1]),
            .sum (level0[i])
        );
    end

    for (genvar i = 0; i < level1_sums; i++) begin : g_level1
        cla_adder #(
            .width (mul_pkg::PRODUCT_WIDTH)
        ) u_add (
            .x   (level0[2*i]),
            .y   (level0[2*i + 1]),
            .sum (level1[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register

    // Sums only load for a valid item, valid itself moves every cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage.valid <= operands.valid;
            if (operands.valid) begin
                stage.sums <= level1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/reduction_back.sv */
// Last three adder levels, the result register and the done pulse
`timescale 1ns/1ns
`default_nettype none

module reduction_back (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire mul_pkg::stage_bundle_t stage,
    output mul_pkg::product_t           product,
    output logic                        done
);

    localparam int level2_sums = mul_pkg::FRONT_SUMS / 2;
    localparam int level3_sums = level2_sums / 2;

    wire mul_pkg::product_t [level2_sums-1:0] level2;
    wire mul_pkg::product_t [level3_sums-1:0] level3;
    wire mul_pkg::product_t                   total;

    ////////////////////////////////////////////////////////////////////////////
    // Adder levels 2 to 4

    for (genvar i = 0; i < level2_sums; i++) begin : g_level2
        cla_adder #(
            .width (mul_pkg::PRODUCT_WIDTH)
        ) u_add (
            .x   (stage.sums[2*i]),
            .y   (stage.sums[2*i + 1]),
            .sum (level2[i])
        );
    end

    for (genvar i = 0; i < level3_sums; i++) begin : g_level3
        cla_adder #(
            .width (mul_pkg::PRODUCT_WIDTH)
        ) u_add (
            .x   (level2[2*i]),
            .y   (level2[2*i + 1]),
            .sum (level3[i])
        );
    end

    // Final sum is the full product
    cla_adder #(
        .width (mul_pkg::PRODUCT_WIDTH)
    ) u_add_final (
        .x   (level3[0]),
        .y   (level3[1]),
        .sum (total)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result register

    // Product holds between results, done marks each new one
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            product <= '0;
            done    <= 1'b0;
        end else begin
            done <= stage.valid;
            if (stage.valid) begin
                product <= total;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mul_top.sv */
// Top level of the three-stage pipelined unsigned multiplier
`timescale 1ns/1ns
`default_nettype none

module mul_top (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire mul_pkg::operand_t a,
    input  wire mul_pkg::operand_t b,
    output mul_pkg::product_t      product,
    output logic                   done
);

    // Bundles carried between the stages
    mul_pkg::operand_bundle_t operands;
    mul_pkg::stage_bundle_t   stage;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline stages

    // Capture on start
    operand_capture u_capture (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .a        (a),
        .b        (b),
        .operands (operands)
    );

    // Partial products down to eight sums
    reduction_front u_front (
        .clock    (clock),
        .reset    (reset),
        .operands (operands),
        .stage    (stage)
    );

    // Eight sums down to the product
    reduction_back u_back (
        .clock   (clock),
        .reset   (reset),
        .stage   (stage),
        .product (product),
        .done    (done)
    );

endmodule

`default_nettype wire

/* test/mul_tb_tasks.svh */
// Value check, failure report, reset and drive tasks, and the directed test tasks

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic check_value(input string name, input mul_pkg::product_t actual,
                               input mul_pkg::product_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic report_failure(input string message);
        errors++;
        $display("ERROR at %0t ns: %s", $time, message);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driving

    // Two reset cycles drop anything in flight
    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        start = 1'b0;
        expected_q.delete();
        repeat (2) @(negedge clock);
        reset = 1'b0;
    endtask

    // One multiply on the next falling edge with its product queued
    task automatic issue_multiply(input mul_pkg::operand_t x, input mul_pkg::operand_t y);
        @(negedge clock);
        start = 1'b1;
        a = x;
        b = y;
        expected_q.push_back(mul_pkg::product_t'(x) * mul_pkg::product_t'(y));
    endtask

    // Start stays low while the operand inputs carry random values
    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clock);
            start = 1'b0;
            a = $random(seed);
            b = $random(seed);
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < limit) begin
            @(negedge clock);
            waited++;
        end
        if (expected_q.size() != 0) begin
            report_failure($sformatf("%0d results still missing after %0d cycles",
                                     expected_q.size(), limit));
        end
    endtask

    // Done must rise two edges after the sampling edge and last one cycle
    task automatic check_latency(input mul_pkg::operand_t x, input mul_pkg::operand_t y);
        mul_pkg::product_t expected;
        expected = mul_pkg::product_t'(x) * mul_pkg::product_t'(y);
        issue_multiply(x, y);
        @(posedge clock);
        repeat (2) begin
            @(negedge clock);
            start = 1'b0;
            a = $random(seed);
            b = $random(seed);
            check_value("done", mul_pkg::product_t'(done), '0);
        end
        @(negedge clock);
        check_value("done", mul_pkg::product_t'(done), 1);
        check_value("product", product, expected);
        @(negedge clock);
        check_value("done", mul_pkg::product_t'(done), '0);
        check_value("product", product, expected);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic check_reset_state();
        @(negedge clock);
        check_value("done", mul_pkg::product_t'(done), '0);
        check_value("product", product, '0);
        repeat (4) begin
            idle_cycles(1);
            check_value("done", mul_pkg::product_t'(done), '0);
            check_value("product", product, '0);
        end
    endtask

    task automatic run_corner_values();
        check_latency(32'h0000_0000, 32'h1234_5678);
        check_latency(32'h0000_0001, 32'hdead_beef);
        check_latency(32'hffff_ffff, 32'h0000_0001);
        check_latency(32'hffff_ffff, 32'hffff_ffff);
        check_value("product", product, 64'hffff_fffe_0000_0001);
    endtask

    // Start high on every cycle and done high for just as long
    task automatic stream_back_to_back(input int count);
        int base_count;
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        max_done_run = 0;
        base_count = done_count;
        for (int i = 0; i < count; i++) begin
            x = $random(seed);
            y = $random(seed);
            issue_multiply(x, y);
        end
        idle_cycles(1);
        wait_for_drain(count + 8);
        check_value("done pulses", mul_pkg::product_t'(done_count - base_count), count);
        check_value("done run length", mul_pkg::product_t'(max_done_run), count);
    endtask

    // Idle gaps of zero to three cycles while the monitor checks the hold
    task automatic stream_with_gaps(input int count);
        int base_count;
        int gap;
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        base_count = done_count;
        for (int i = 0; i < count; i++) begin
            x = $random(seed);
            y = $random(seed);
            issue_multiply(x, y);
            gap = $random(seed) & 3;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_for_drain(8);
        check_value("done pulses", mul_pkg::product_t'(done_count - base_count), count);
    endtask

    task automatic reset_during_flight();
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        x = $random(seed);
        y = $random(seed);
        issue_multiply(x, y);
        issue_multiply(y, x);
        apply_reset();
        check_value("product", product, '0);
        repeat (5) begin
            idle_cycles(1);
            check_value("done", mul_pkg::product_t'(done), '0);
            check_value("product", product, '0);
        end
    endtask

/* test/mul_tb.sv */
// Testbench top with clock, reset, watchdog, result monitor, test sequence and closing report
`timescale 1ns/1ns
`default_nettype none

module mul_tb;

    localparam int clock_period = 8;

    // Cycle budget of the whole test sequence
    localparam int test_cycles = 260;
    localparam int watchdog_margin = 400;

    logic              clock;
    logic              reset;
    logic              start;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    mul_pkg::product_t product;
    logic              done;

    // Expected products in issue order
    mul_pkg::product_t expected_q[$];

    // Result the DUT must hold between done pulses
    mul_pkg::product_t last_product;

    int seed;
    int checks;
    int errors;
    int done_count;
    int done_run;
    int max_done_run;

    mul_top dut0 (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done)
    );

    `include "mul_tb_tasks.svh"

    always #(clock_period / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Result monitor

    // Registered outputs are read on the rising edge, before they update
    always @(posedge clock) begin
        if (reset) begin
            last_product = '0;
            done_run = 0;
        end else if (done) begin
            done_count++;
            done_run++;
            if (done_run > max_done_run) begin
                max_done_run = done_run;
            end
            if (expected_q.size() == 0) begin
                report_failure("done pulse while no multiply was in flight");
                // Track the stray value so the hold check does not cascade
                last_product = product;
            end else begin
                last_product = expected_q.pop_front();
                check_value("product", product, last_product);
            end
        end else begin
            done_run = 0;
            check_value("product", product, last_product);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog

    initial begin
        #(test_cycles * clock_period + watchdog_margin);
        $display("Watchdog expired before the test sequence finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        a = '0;
        b = '0;
        seed = 32'h1bde_018b;
        checks = 0;
        errors = 0;
        done_count = 0;
        done_run = 0;
        max_done_run = 0;
        last_product = '0;

        apply_reset();
        check_reset_state();
        run_corner_values();
        stream_back_to_back(40);
        stream_with_gaps(30);
        reset_during_flight();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mul_top.f */
source/mul_pkg.sv
source/cla_adder.sv
source/operand_capture.sv
source/reduction_front.sv
source/reduction_back.sv
source/mul_top.sv
+incdir+test
test/mul_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the multiplier testbench with Verilator, passes only on the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module mul_tb -f mul_top.f -o mul_sim \
    > build.log 2>&1 \
    && ./obj_dir/mul_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qx "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
